//--- mult_unit.f
+incdir+src
src/mult_pkg.sv
src/mulh_ctrl.sv
src/short_mac.sv
src/dot_mult.sv
src/mult_unit.sv
test/mult_unit_sva.sv
test/mult_unit_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the mult_unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f mult_unit.f --top-module mult_unit_tb

# an assertion stops the simulator early, so its exit status is not used here
out=$(./obj_dir/Vmult_unit_tb 2>&1 || true)
echo "$out"

if grep -q "^ALL TESTS PASSED$" <<< "$out"; then
  exit 0
fi
exit 1

//--- src/dot_mult.sv
`timescale 1ns/1ps
`include "mult_consts.svh"

module dot_mult import mult_pkg::*; (
  input  mult_req_t             req_i,
  output logic [`MULT_XLEN-1:0] dot8_o,
  output logic [`MULT_XLEN-1:0] dot16_o
);

  localparam int NB = `MULT_XLEN / `MULT_BYTE;
  localparam int NH = `MULT_XLEN / `MULT_HALF;

  // 9x9 lanes for bytes, 17x17 lanes for halfwords
  logic [NB-1:0][`MULT_BYTE:0]     char_a;
  logic [NB-1:0][`MULT_BYTE:0]     char_b;
  logic [NB-1:0][2*`MULT_BYTE+1:0] char_mul;
  logic [NH-1:0][`MULT_HALF:0]     half_a;
  logic [NH-1:0][`MULT_HALF:0]     half_b;
  logic [NH-1:0][2*`MULT_HALF+1:0] half_mul;

  ////////////////////////////////////////////////////////////////////////////
  // byte lanes
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < NB; i++) begin
      // dot_signed bit 1 extends A, bit 0 extends B
      char_a[i]   = {req_i.dot_signed[1] & req_i.op_a.b[i][`MULT_BYTE-1], req_i.op_a.b[i]};
      char_b[i]   = {req_i.dot_signed[0] & req_i.op_b.b[i][`MULT_BYTE-1], req_i.op_b.b[i]};
      char_mul[i] = $signed(char_a[i]) * $signed(char_b[i]);
    end
  end

  always_comb begin
    dot8_o = req_i.op_c;
    for (int i = 0; i < NB; i++) begin
      // 18-bit products are exact, sign extend into the sum
      dot8_o = dot8_o + `MULT_XLEN'($signed(char_mul[i]));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // halfword lanes
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < NH; i++) begin
      half_a[i]   = {req_i.dot_signed[1] & req_i.op_a.h[i][`MULT_HALF-1], req_i.op_a.h[i]};
      half_b[i]   = {req_i.dot_signed[0] & req_i.op_b.h[i][`MULT_HALF-1], req_i.op_b.h[i]};
      half_mul[i] = $signed(half_a[i]) * $signed(half_b[i]);
    end
  end

  always_comb begin
    dot16_o = req_i.op_c;
    for (int i = 0; i < NH; i++) begin
      // only the low word of each product reaches the result
      dot16_o = dot16_o + half_mul[i][`MULT_XLEN-1:0];
    end
  end

endmodule

//--- src/mulh_ctrl.sv
`timescale 1ns/1ps
`include "mult_consts.svh"

module mulh_ctrl import mult_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       enable_i,
  input  mult_req_t  req_i,
  input  logic       ex_ready_i,
  input  logic       mac_carry_i,
  output short_ctl_t ctl_o,
  output logic       multicycle_o,
  output logic       ready_o
);

  typedef enum logic [2:0] {IDLE, STEP0, STEP1, STEP2, FINISH} mulh_state_e;

  mulh_state_e state_q;
  mulh_state_e state_d;
  logic        carry_q;
  logic        carry_save;
  logic        carry_clear;

  ////////////////////////////////////////////////////////////////////////////
  // step sequencing and datapath controls
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d           = state_q;
    ctl_o.active      = 1'b1;
    ctl_o.round_en    = 1'b0;
    ctl_o.imm         = '0;
    ctl_o.subword     = 2'b00;
    ctl_o.signed_sel  = 2'b00;
    ctl_o.shift_arith = 1'b0;
    ctl_o.carry       = carry_q;
    carry_save        = 1'b0;
    carry_clear       = 1'b0;
    multicycle_o      = 1'b0;
    ready_o           = 1'b0;

    case (state_q)
      IDLE: begin
        // plain subword multiply, controls straight from the request
        ctl_o.active      = 1'b0;
        ctl_o.round_en    = (req_i.op == MUL_IR);
        ctl_o.imm         = req_i.imm;
        ctl_o.subword     = {2{req_i.short_subword}};
        ctl_o.signed_sel  = req_i.short_signed;
        // B signed implies A signed, so bit 0 decides
        ctl_o.shift_arith = req_i.short_signed[0];
        ready_o           = 1'b1;
        if (enable_i && (req_i.op == MUL_H)) begin
          ready_o = 1'b0;
          state_d = STEP0;
        end
      end
      STEP0: begin
        // al*bl, unsigned, never carries; keep its upper half
        multicycle_o = 1'b1;
        ctl_o.imm    = `MULT_IMM_W'(`MULT_MULH_SHIFT);
        state_d      = STEP1;
      end
      STEP1: begin
        // al*bh is signed only if B is; 33-bit sum kept with carry
        multicycle_o      = 1'b1;
        ctl_o.signed_sel  = {req_i.short_signed[1], 1'b0};
        ctl_o.subword     = 2'b10;
        ctl_o.shift_arith = 1'b1;
        carry_save        = 1'b1;
        state_d           = STEP2;
      end
      STEP2: begin
        // ah*bl is signed only if A is
        multicycle_o      = 1'b1;
        ctl_o.signed_sel  = {1'b0, req_i.short_signed[0]};
        ctl_o.subword     = 2'b01;
        ctl_o.imm         = `MULT_IMM_W'(`MULT_MULH_SHIFT);
        ctl_o.shift_arith = 1'b1;
        // bits above 32 are shifted back in, no carry left over
        carry_save        = 1'b1;
        carry_clear       = 1'b1;
        state_d           = FINISH;
      end
      FINISH: begin
        // ah*bh closes the sum, result valid while held here
        ctl_o.signed_sel = req_i.short_signed;
        ctl_o.subword    = 2'b11;
        ready_o          = 1'b1;
        if (ex_ready_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
      carry_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (carry_save) begin
        carry_q <= ~carry_clear & mac_carry_i;
      end else if (ex_ready_i) begin
        // next instruction starts clean
        carry_q <= 1'b0;
      end
    end
  end

endmodule

//--- src/mult_consts.svh
`ifndef MULT_CONSTS_SVH
`define MULT_CONSTS_SVH

// operand and result width of the unit
`define MULT_XLEN 32

// subword sizes used by the short datapath and the dot products
`define MULT_HALF 16
`define MULT_BYTE 8

// shift immediate of MUL_I / MUL_IR
`define MULT_IMM_W 5

// width of the operator encoding
`define MULT_OP_W 3

// realignment shift applied in MULH steps 0 and 2
`define MULT_MULH_SHIFT 16

`endif

//--- src/mult_pkg.sv
`include "mult_consts.svh"

package mult_pkg;

  // operator encoding, matches the decoder of the core
  typedef enum logic [`MULT_OP_W-1:0] {
    MUL_MAC32 = 3'b000,
    MUL_MSU32 = 3'b001,
    MUL_I     = 3'b010,
    MUL_IR    = 3'b011,
    MUL_DOT8  = 3'b100,
    MUL_DOT16 = 3'b101,
    MUL_H     = 3'b110
  } mult_op_e;

  // one operand word, seen as bytes or as halfwords
  typedef union packed {
    logic [`MULT_XLEN/`MULT_BYTE-1:0][`MULT_BYTE-1:0] b;
    logic [`MULT_XLEN/`MULT_HALF-1:0][`MULT_HALF-1:0] h;
  } simd_word_u;

  // complete request as issued by the EX stage
  typedef struct packed {
    mult_op_e               op;
    // high halves for MUL_I / MUL_IR
    logic                   short_subword;
    // bit 0 for A, bit 1 for B
    logic [1:0]             short_signed;
    // bit 1 for A, bit 0 for B
    logic [1:0]             dot_signed;
    logic [`MULT_IMM_W-1:0] imm;
    simd_word_u             op_a;
    simd_word_u             op_b;
    simd_word_u             op_c;
  } mult_req_t;

  // controls of the 16x16 short datapath
  typedef struct packed {
    // a MULH step owns the datapath
    logic                   active;
    logic                   round_en;
    logic [`MULT_IMM_W-1:0] imm;
    // bit 0 picks the A half, bit 1 the B half
    logic [1:0]             subword;
    logic [1:0]             signed_sel;
    logic                   shift_arith;
    // saved carry, extends op_c during MULH
    logic                   carry;
  } short_ctl_t;

endpackage

//--- src/mult_unit.sv
`timescale 1ns/1ps
`include "mult_consts.svh"

module mult_unit import mult_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  enable_i,
  input  mult_req_t             req_i,
  input  logic                  ex_ready_i,
  output logic [`MULT_XLEN-1:0] result_o,
  output logic                  multicycle_o,
  output logic                  ready_o
);

  short_ctl_t            short_ctl;
  mult_req_t             short_req;
  logic                  mac_carry;
  logic [`MULT_XLEN-1:0] short_result;
  logic [`MULT_XLEN-1:0] mulh_acc_q;
  logic [`MULT_XLEN-1:0] dot8_result;
  logic [`MULT_XLEN-1:0] dot16_result;

  logic                  int_is_msu;
  logic [`MULT_XLEN-1:0] int_op_a;
  logic [`MULT_XLEN-1:0] int_corr;
  logic [`MULT_XLEN-1:0] int_result;

  ////////////////////////////////////////////////////////////////////////////
  // 32-bit MAC / MSU
  ////////////////////////////////////////////////////////////////////////////

  assign int_is_msu = (req_i.op == MUL_MSU32);

  // -a*b = ~a*b + b, so one multiplier serves both
  assign int_op_a = req_i.op_a ^ {`MULT_XLEN{int_is_msu}};
  assign int_corr = req_i.op_b & {`MULT_XLEN{int_is_msu}};

  // low word only, signedness does not matter modulo 2^32
  assign int_result = req_i.op_c + int_corr + int_op_a * req_i.op_b;

  ////////////////////////////////////////////////////////////////////////////
  // MULH sequencing and the short datapath
  ////////////////////////////////////////////////////////////////////////////

  mulh_ctrl u_mulh_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (enable_i),
    .req_i        (req_i),
    .ex_ready_i   (ex_ready_i),
    .mac_carry_i  (mac_carry),
    .ctl_o        (short_ctl),
    .multicycle_o (multicycle_o),
    .ready_o      (ready_o)
  );

  // partial sum of the MULH steps, fed back as accumulator
  always_ff @(posedge clk) begin
    if (multicycle_o) begin
      mulh_acc_q <= short_result;
    end else if (!short_ctl.active) begin
      // idle, so STEP0 starts from zero
      mulh_acc_q <= '0;
    end
  end

  // op_c is replaced by the running partial sum while MULH owns the datapath
  always_comb begin
    short_req = req_i;
    if (short_ctl.active) begin
      short_req.op_c = mulh_acc_q;
    end
  end

  short_mac u_short_mac (
    .req_i       (short_req),
    .ctl_i       (short_ctl),
    .result_o    (short_result),
    .mac_carry_o (mac_carry)
  );

  dot_mult u_dot_mult (
    .req_i   (req_i),
    .dot8_o  (dot8_result),
    .dot16_o (dot16_result)
  );

  ////////////////////////////////////////////////////////////////////////////
  // result mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    result_o = '0;
    unique case (req_i.op)
      MUL_MAC32, MUL_MSU32: result_o = int_result;
      MUL_I, MUL_IR, MUL_H: result_o = short_result;
      MUL_DOT8:             result_o = dot8_result;
      MUL_DOT16:            result_o = dot16_result;
      default:              result_o = '0;
    endcase
  end

endmodule

//--- src/short_mac.sv
`timescale 1ns/1ps
`include "mult_consts.svh"

module short_mac import mult_pkg::*; (
  input  mult_req_t              req_i,
  input  short_ctl_t             ctl_i,
  output logic [`MULT_XLEN-1:0]  result_o,
  output logic                   mac_carry_o
);

  // 17-bit operands, 34-bit products and sums
  logic [`MULT_HALF:0]       op_a_ext;
  logic [`MULT_HALF:0]       op_b_ext;
  logic [2*`MULT_HALF+1:0]   op_c_ext;
  logic [2*`MULT_HALF+1:0]   mul;
  logic [`MULT_XLEN-1:0]     round_one;
  logic [2*`MULT_HALF+1:0]   round_val;
  logic [2*`MULT_HALF+1:0]   sum;
  logic                      msb_hi;
  logic                      msb_lo;
  logic [2*`MULT_HALF+1:0]   shifted;

  ////////////////////////////////////////////////////////////////////////////
  // halfword selection and extension
  ////////////////////////////////////////////////////////////////////////////

  assign op_a_ext[`MULT_HALF-1:0] = ctl_i.subword[0] ? req_i.op_a.h[1] : req_i.op_a.h[0];
  assign op_b_ext[`MULT_HALF-1:0] = ctl_i.subword[1] ? req_i.op_b.h[1] : req_i.op_b.h[0];

  assign op_a_ext[`MULT_HALF] = ctl_i.signed_sel[0] & op_a_ext[`MULT_HALF-1];
  assign op_b_ext[`MULT_HALF] = ctl_i.signed_sel[1] & op_b_ext[`MULT_HALF-1];

  // during MULH the saved carry is bit 32 of a signed 33-bit partial sum
  assign op_c_ext = ctl_i.active ? {ctl_i.carry, ctl_i.carry, req_i.op_c}
                                 : {{2{req_i.op_c[`MULT_XLEN-1]}}, req_i.op_c};

  ////////////////////////////////////////////////////////////////////////////
  // multiply, accumulate, round
  ////////////////////////////////////////////////////////////////////////////

  assign mul = $signed(op_a_ext) * $signed(op_b_ext);

  // half an lsb of the result, i.e. 2^(imm-1); zero for imm = 0
  assign round_one = `MULT_XLEN'(1) << ctl_i.imm;
  assign round_val = ctl_i.round_en ? {3'b000, round_one[`MULT_XLEN-1:1]} : '0;

  assign sum = op_c_ext + mul + round_val;

  // carry out of the low word, saved between MULH steps
  assign mac_carry_o = sum[`MULT_XLEN];

  ////////////////////////////////////////////////////////////////////////////
  // right shift
  ////////////////////////////////////////////////////////////////////////////

  // MULH keeps the two extra sum bits, plain ops extend from bit 31
  assign msb_hi = ctl_i.active ? sum[`MULT_XLEN+1] : sum[`MULT_XLEN-1];
  assign msb_lo = ctl_i.active ? sum[`MULT_XLEN]   : sum[`MULT_XLEN-1];

  // logical shift when not arithmetic: top bits forced to zero
  assign shifted = $signed({ctl_i.shift_arith & msb_hi,
                            ctl_i.shift_arith & msb_lo,
                            sum[`MULT_XLEN-1:0]}) >>> ctl_i.imm;

  assign result_o = shifted[`MULT_XLEN-1:0];

endmodule

//--- test/mult_trace.txt
# columns, all hex: op sgn sub imm op_a op_b op_c expected
# sgn feeds short_signed and dot_signed; op 0 MAC32 1 MSU32 2 I 3 IR 4 DOT8 5 DOT16 6 H
0 0 0 00 00000003 00000005 00000010 0000001f
0 0 0 00 ffffffff 00000002 00000000 fffffffe
0 0 0 00 12345678 00000010 00000001 23456781
1 0 0 00 00000003 00000005 00000010 00000001
1 0 0 00 00000002 00000003 00000000 fffffffa
6 0 0 00 ffffffff ffffffff 00000000 fffffffe
1 0 0 00 ffffffff ffffffff 00000005 00000004
2 0 0 00 00000003 00000004 00000001 0000000d
2 3 0 04 1234ffff 56780010 00000000 ffffffff
2 3 1 02 fffe0000 00030000 00000000 fffffffe
2 0 1 08 ffff0001 00020005 00000002 00000200
2 0 0 04 0000ffff 0000ffff 00000000 0fffe000
6 3 0 00 ffffffff ffffffff 00000000 00000000
6 3 0 00 80000000 80000000 00000000 40000000
3 3 0 04 00000007 00000003 00000000 00000001
3 3 0 01 0000ffff 00000003 00000000 ffffffff
3 0 1 00 00050000 00060000 00000001 0000001f
3 0 0 0a 00001000 00000100 00000000 00000400
6 1 0 00 ffffffff ffffffff 00000000 ffffffff
4 0 0 00 01020304 05060708 00000000 00000046
4 3 0 00 ff0102fe 02ff0304 00000010 0000000b
4 2 0 00 000000ff 000000ff 00000000 ffffff01
6 3 0 00 00000002 fffffffd 00000000 ffffffff
5 0 0 00 00020003 00040005 00000001 00000018
5 3 0 00 ffff0002 0003fffe 00000000 fffffff9
5 1 0 00 0000ffff 0000ffff 00000000 ffff0001
6 1 0 00 80000000 00000002 00000000 ffffffff
6 0 0 00 12345678 00010000 00000000 00001234

//--- test/mult_unit_sva.sv
`timescale 1ns/1ps
`include "mult_consts.svh"

module mult_unit_sva import mult_pkg::*; (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  enable_i,
  input mult_req_t             req_i,
  input logic                  ex_ready_i,
  input logic [`MULT_XLEN-1:0] result_o,
  input logic                  multicycle_o,
  input logic                  ready_o
);

  logic mulh_start;
  logic finish_held;

  // IDLE taking a MULH is the only cycle with both flags low
  assign mulh_start = enable_i && (req_i.op == MUL_H) && !ready_o && !multicycle_o;

  // FINISH stalled by the next stage
  assign finish_held = enable_i && (req_i.op == MUL_H) && ready_o && !ex_ready_i;

  ////////////////////////////////////////////////////////////////////////////
  // control output rules
  ////////////////////////////////////////////////////////////////////////////

  a_flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(multicycle_o && ready_o))
    else $error("multicycle_o and ready_o high in the same cycle");

  // STEP0..STEP2 keep the pipeline stalled
  a_mulh_steps: assert property (@(posedge clk) disable iff (!rst_n)
    mulh_start |=> !ready_o ##1 !ready_o ##1 !ready_o)
    else $error("ready_o not low for three cycles after a MULH start");

  a_reset_ready: assert property (@(posedge clk)
    $rose(rst_n) |-> ready_o && !multicycle_o)
    else $error("ready_o low in the first cycle after reset");

  // back-pressure keeps FINISH and its result
  a_finish_hold: assert property (@(posedge clk) disable iff (!rst_n)
    finish_held |=> ready_o && $stable(result_o))
    else $error("FINISH not held while ex_ready_i is low");

endmodule

bind mult_unit mult_unit_sva u_mult_unit_sva (
  .clk          (clk),
  .rst_n        (rst_n),
  .enable_i     (enable_i),
  .req_i        (req_i),
  .ex_ready_i   (ex_ready_i),
  .result_o     (result_o),
  .multicycle_o (multicycle_o),
  .ready_o      (ready_o)
);

//--- test/mult_unit_tb.sv
`timescale 1ns/1ps
`include "mult_consts.svh"

module mult_unit_tb import mult_pkg::*; ();

  // cap of every wait loop, in cycles
  localparam int MAX_WAIT = 20;

  logic                  clk;
  logic                  rst_n;
  logic                  enable_i;
  mult_req_t             req_i;
  logic                  ex_ready_i;
  logic [`MULT_XLEN-1:0] result_o;
  logic                  multicycle_o;
  logic                  ready_o;

  integer seed;
  int     errors;
  int     test_errors;
  int     tests_run;
  int     tests_bad;
  logic   timed_out;

  mult_unit dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (enable_i),
    .req_i        (req_i),
    .ex_ready_i   (ex_ready_i),
    .result_o     (result_o),
    .multicycle_o (multicycle_o),
    .ready_o      (ready_o)
  );

  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_result(input logic [`MULT_XLEN-1:0] actual,
                              input logic [`MULT_XLEN-1:0] expected,
                              input string name);
    if (actual !== expected) begin
      $display("Error: %s = 0x%h, expected 0x%h", name, actual, expected);
      test_errors++;
    end
  endtask

  task automatic check_flag(input logic actual, input logic expected, input string name);
    if (actual !== expected) begin
      $display("Error: %s = 0x%h, expected 0x%h", name, actual, expected);
      test_errors++;
    end
  endtask

  // one line per test, then the error count moves to the total
  task automatic close_test(input string label);
    tests_run++;
    if (test_errors != 0) begin
      tests_bad++;
      $display("test %0d %s: %0d mismatches", tests_run, label, test_errors);
    end else begin
      $display("test %0d %s: ok", tests_run, label);
    end
    errors += test_errors;
    test_errors = 0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // request drivers
  ////////////////////////////////////////////////////////////////////////////

  // result is combinational, checked in the issue cycle
  task automatic run_single(input mult_req_t req, input logic [`MULT_XLEN-1:0] expected);
    @(posedge clk);
    req_i      <= req;
    enable_i   <= 1'b1;
    ex_ready_i <= 1'b1;
    @(negedge clk);
    check_result(result_o, expected, "result_o");
    check_flag(ready_o, 1'b1, "ready_o");
    check_flag(multicycle_o, 1'b0, "multicycle_o");
  endtask

  task automatic run_mulh(input mult_req_t req, input logic [`MULT_XLEN-1:0] expected);
    int   hold;
    int   waited;
    int   busy;
    logic done;
    // cycles of back-pressure in FINISH
    hold   = $unsigned($random(seed)) % 4;
    waited = 0;
    busy   = 0;
    done   = 1'b0;
    @(posedge clk);
    req_i      <= req;
    enable_i   <= 1'b1;
    ex_ready_i <= (hold == 0);
    @(negedge clk);
    // start cycle, ready_o falls at once
    check_flag(ready_o, 1'b0, "ready_o");
    check_flag(multicycle_o, 1'b0, "multicycle_o");
    while (!done && waited < MAX_WAIT) begin
      @(negedge clk);
      waited++;
      if (multicycle_o) begin
        busy++;
      end else if (ready_o) begin
        done = 1'b1;
      end
    end
    if (!done) begin
      $display("timeout waiting for ready_o after the MULH start");
      timed_out = 1'b1;
      test_errors++;
    end else begin
      if (busy != 3) begin
        $display("multicycle_o was high for %0d cycles instead of 3", busy);
        test_errors++;
      end
      check_result(result_o, expected, "result_o");
      // FINISH must hold ready_o and the result until ex_ready_i returns
      for (int i = 1; i <= hold; i++) begin
        @(posedge clk);
        if (i == hold) begin
          ex_ready_i <= 1'b1;
        end
        @(negedge clk);
        check_flag(ready_o, 1'b1, "ready_o");
        check_flag(multicycle_o, 1'b0, "multicycle_o");
        check_result(result_o, expected, "result_o");
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int                    fd;
    int                    n;
    string                 line;
    logic [`MULT_OP_W-1:0] op_v;
    logic [1:0]            sgn_v;
    logic [0:0]            sub_v;
    logic [`MULT_IMM_W-1:0] imm_v;
    logic [`MULT_XLEN-1:0] a_v;
    logic [`MULT_XLEN-1:0] b_v;
    logic [`MULT_XLEN-1:0] c_v;
    logic [`MULT_XLEN-1:0] exp_v;
    mult_req_t             req;
    clk         = 1'b0;
    rst_n       = 1'b0;
    enable_i    = 1'b0;
    ex_ready_i  = 1'b1;
    req_i       = '0;
    seed        = 83423;
    errors      = 0;
    test_errors = 0;
    tests_run   = 0;
    tests_bad   = 0;
    timed_out   = 1'b0;

    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_flag(ready_o, 1'b1, "ready_o");
    check_flag(multicycle_o, 1'b0, "multicycle_o");
    close_test("reset");

    fd = $fopen("test/mult_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open test/mult_trace.txt");
      errors++;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        line = "";
        n = $fgets(line, fd);
        // comment and blank lines carry no vector
        if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                      op_v, sgn_v, sub_v, imm_v, a_v, b_v, c_v, exp_v);
          if (n != 8) begin
            $display("trace line with %0d fields instead of 8", n);
            errors++;
          end else begin
            req               = '0;
            req.op            = mult_op_e'(op_v);
            req.short_subword = sub_v[0];
            req.short_signed  = sgn_v;
            req.dot_signed    = sgn_v;
            req.imm           = imm_v;
            req.op_a          = a_v;
            req.op_b          = b_v;
            req.op_c          = c_v;
            if (req.op == MUL_H) begin
              run_mulh(req, exp_v);
            end else begin
              run_single(req, exp_v);
            end
            close_test(req.op.name());
          end
        end
      end
      $fclose(fd);
      // lets a trailing MULH leave FINISH
      @(posedge clk);
    end

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_bad, errors);
    if (errors == 0 && tests_run > 1) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
